// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_npc
FILELIST ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps
PASS_TEXT ?= >>> PASS

.PHONY: help build test clean

help:
	@echo "targets:"
	@echo "  test   build $(TOP) with verilator from $(FILELIST) and run it"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "  help   show this list"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# status comes from the search for the pass line
test: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)

// File: src/bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter import npc_pkg::*; (
	input logic clk,
	input logic rst,
	mem_bus_if.slave fetch_bus,
	mem_bus_if.slave lsu_bus,
	mem_bus_if.master mem_bus
);

	// read channel owner, ar transfer until r transfer
	arb_owner_t owner;
	logic grant_lsu;
	logic grant_fetch;
	logic ar_fire;
	logic r_fire;

	// ******************************
	// read address, lsu first
	// ******************************

	// grant only while nobody holds the channel
	assign grant_lsu = (owner == OWN_NONE) && lsu_bus.arvalid;
	assign grant_fetch = (owner == OWN_NONE) && !lsu_bus.arvalid && fetch_bus.arvalid;

	assign mem_bus.arvalid = grant_lsu || grant_fetch;
	assign mem_bus.araddr = grant_lsu ? lsu_bus.araddr : fetch_bus.araddr;
	// a waiting master sees arready low
	assign lsu_bus.arready = grant_lsu && mem_bus.arready;
	assign fetch_bus.arready = grant_fetch && mem_bus.arready;

	assign ar_fire = mem_bus.arvalid && mem_bus.arready;
	assign r_fire = mem_bus.rvalid && mem_bus.rready;

	// ******************************
	// read data, steered to owner
	// ******************************

	assign fetch_bus.rvalid = mem_bus.rvalid && (owner == OWN_FETCH);
	assign lsu_bus.rvalid = mem_bus.rvalid && (owner == OWN_LSU);
	// data fans out, rvalid qualifies it
	assign fetch_bus.rdata = mem_bus.rdata;
	assign lsu_bus.rdata = mem_bus.rdata;
	assign mem_bus.rready = (owner == OWN_FETCH) ? fetch_bus.rready :
		(owner == OWN_LSU) ? lsu_bus.rready : 1'b0;

	always_ff @(posedge clk) begin
		if (rst)
			owner <= OWN_NONE;
		else if (ar_fire)
			owner <= grant_lsu ? OWN_LSU : OWN_FETCH;
		else if (r_fire)
			owner <= OWN_NONE;
	end

	// ******************************
	// writes, lsu only
	// ******************************

	assign mem_bus.awaddr = lsu_bus.awaddr;
	assign mem_bus.awvalid = lsu_bus.awvalid;
	assign lsu_bus.awready = mem_bus.awready;
	assign mem_bus.wdata = lsu_bus.wdata;
	assign mem_bus.wstrb = lsu_bus.wstrb;
	assign mem_bus.wvalid = lsu_bus.wvalid;
	assign lsu_bus.wready = mem_bus.wready;
	assign lsu_bus.bvalid = mem_bus.bvalid;
	assign mem_bus.bready = lsu_bus.bready;

	// fetch never writes
	assign fetch_bus.awready = 1'b0;
	assign fetch_bus.wready = 1'b0;
	assign fetch_bus.bvalid = 1'b0;

	// ******************************
	// checks
	// ******************************

	a_owner_held: assert property (@(posedge clk) disable iff (rst)
		mem_bus.rvalid && !mem_bus.rready |=> owner == $past(owner));

	// response always has exactly one receiver
	a_rvalid_owner: assert property (@(posedge clk) disable iff (rst)
		mem_bus.rvalid |-> (owner != OWN_NONE) && (fetch_bus.rvalid != lsu_bus.rvalid));

endmodule

`default_nettype wire

// File: src/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit import npc_pkg::*; (
	input logic clk,
	input logic rst,
	input logic inst_ready,
	input logic redirect,
	input addr_t redirect_pc,
	output addr_t pc,
	output inst_t inst,
	output logic inst_valid,
	mem_bus_if.master bus
);

	fetch_state_t state;
	// word address of the read in flight
	addr_t fetch_addr;
	addr_t pc_next;
	// redirect seen while a read was outstanding
	logic pending;
	logic ar_fire;
	logic r_fire;
	logic accept;
	logic drop;

	assign ar_fire = bus.arvalid && bus.arready;
	assign r_fire = bus.rvalid && bus.rready;
	// redirect wins over acceptance
	assign accept = inst_valid && inst_ready && !redirect;
	// returning data belongs to a stale pc
	assign drop = pending || redirect;

	always_comb begin
		if (redirect)
			pc_next = redirect_pc;
		else if (accept)
			pc_next = pc + addr_t'(4);
		else
			pc_next = pc;
	end

	// one read per instruction, address held in a register
	assign bus.arvalid = (state == IDLE_ADDR);
	assign bus.araddr = fetch_addr;
	assign bus.rready = (state == WAIT_DATA);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE_ADDR;
			pc <= RESET_PC;
			fetch_addr <= {RESET_PC[ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
			pending <= 1'b0;
			inst_valid <= 1'b0;
		end else begin
			pc <= pc_next;
			case (state)
				IDLE_ADDR: begin
					if (ar_fire)
						state <= WAIT_DATA;
					// address already on the bus, finish it and throw it away
					if (redirect)
						pending <= 1'b1;
				end
				WAIT_DATA: begin
					if (r_fire && drop) begin
						// refetch from the new pc
						state <= IDLE_ADDR;
						fetch_addr <= {pc_next[ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
						pending <= 1'b0;
					end else if (r_fire) begin
						state <= HOLD_INST;
						inst_valid <= 1'b1;
					end else if (redirect) begin
						pending <= 1'b1;
					end
				end
				HOLD_INST: begin
					// taken or flushed, either way start the next read
					if (redirect || inst_ready) begin
						state <= IDLE_ADDR;
						inst_valid <= 1'b0;
						fetch_addr <= {pc_next[ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
					end
				end
				default: state <= IDLE_ADDR;
			endcase
		end
	end

	// pick the half word that pc points at
	always_ff @(posedge clk) begin
		if (state == WAIT_DATA && r_fire && !drop)
			inst <= pc[2] ? bus.rdata[INST_W +: INST_W] : bus.rdata[0 +: INST_W];
	end

	// ******************************
	// checks
	// ******************************

	a_no_inst_in_wait: assert property (@(posedge clk) disable iff (rst)
		state == WAIT_DATA |-> !inst_valid);

	a_araddr_stable: assert property (@(posedge clk) disable iff (rst)
		bus.arvalid && !bus.arready |=> bus.arvalid && $stable(bus.araddr));

endmodule

`default_nettype wire

// File: src/lsu.sv
`timescale 1ns/1ps
`default_nettype none

module lsu import npc_pkg::*; (
	input logic clk,
	input logic rst,
	input logic ls_req,
	input logic ls_write,
	input addr_t ls_addr,
	input data_t ls_wdata,
	input strb_t ls_strb,
	output logic ls_busy,
	output logic ls_done,
	output data_t ls_rdata,
	mem_bus_if.master bus
);

	lsu_state_t state;
	// latched command
	addr_t addr_q;
	data_t wdata_q;
	strb_t strb_q;
	// halves of a store already taken by the slave
	logic aw_sent;
	logic w_sent;
	logic start;
	logic ar_fire;
	logic r_fire;
	logic aw_fire;
	logic w_fire;
	logic b_fire;
	logic wr_sent;

	assign start = ls_req && !ls_busy;
	assign ar_fire = bus.arvalid && bus.arready;
	assign r_fire = bus.rvalid && bus.rready;
	assign aw_fire = bus.awvalid && bus.awready;
	assign w_fire = bus.wvalid && bus.wready;
	assign b_fire = bus.bvalid && bus.bready;
	// aw and w may be taken on different edges
	assign wr_sent = (aw_sent || aw_fire) && (w_sent || w_fire);

	// load side
	assign bus.arvalid = (state == RD_ADDR);
	assign bus.araddr = addr_q;
	assign bus.rready = (state == RD_DATA);

	// store side, aw and w raised together
	assign bus.awvalid = (state == WR_REQ) && !aw_sent;
	assign bus.awaddr = addr_q;
	assign bus.wvalid = (state == WR_REQ) && !w_sent;
	assign bus.wdata = wdata_q;
	assign bus.wstrb = strb_q;
	assign bus.bready = (state == WR_RESP);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			ls_busy <= 1'b0;
			ls_done <= 1'b0;
			aw_sent <= 1'b0;
			w_sent <= 1'b0;
		end else begin
			// done is a single cycle pulse
			ls_done <= 1'b0;
			case (state)
				IDLE: begin
					if (start) begin
						state <= ls_write ? WR_REQ : RD_ADDR;
						ls_busy <= 1'b1;
					end
				end
				RD_ADDR: begin
					if (ar_fire)
						state <= RD_DATA;
				end
				RD_DATA: begin
					if (r_fire) begin
						state <= IDLE;
						ls_busy <= 1'b0;
						ls_done <= 1'b1;
					end
				end
				WR_REQ: begin
					aw_sent <= aw_sent || aw_fire;
					w_sent <= w_sent || w_fire;
					if (wr_sent) begin
						state <= WR_RESP;
						aw_sent <= 1'b0;
						w_sent <= 1'b0;
					end
				end
				WR_RESP: begin
					if (b_fire) begin
						state <= IDLE;
						ls_busy <= 1'b0;
						ls_done <= 1'b1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// command and load data registers
	always_ff @(posedge clk) begin
		if (start) begin
			addr_q <= ls_addr;
			wdata_q <= ls_wdata;
			strb_q <= ls_strb;
		end
		// held until the next load returns
		if (r_fire)
			ls_rdata <= bus.rdata;
	end

	// ******************************
	// checks
	// ******************************

	a_req_when_free: assert property (@(posedge clk) disable iff (rst)
		ls_req |-> !ls_busy);

	a_done_pulse: assert property (@(posedge clk) disable iff (rst)
		ls_done |=> !ls_done);

endmodule

`default_nettype wire

// File: src/mem_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mem_bus_if import npc_pkg::*; ();

	// read address channel
	addr_t araddr;
	logic arvalid;
	logic arready;

	// read data channel, response always okay
	data_t rdata;
	logic rvalid;
	logic rready;

	// write address channel
	addr_t awaddr;
	logic awvalid;
	logic awready;

	// write data channel, single beat
	data_t wdata;
	strb_t wstrb;
	logic wvalid;
	logic wready;

	// write response channel
	logic bvalid;
	logic bready;

	// requester side
	modport master (
		output araddr, arvalid, input arready,
		input rdata, rvalid, output rready,
		output awaddr, awvalid, input awready,
		output wdata, wstrb, wvalid, input wready,
		input bvalid, output bready
	);

	// responder side
	modport slave (
		input araddr, arvalid, output arready,
		output rdata, rvalid, input rready,
		input awaddr, awvalid, output awready,
		input wdata, wstrb, wvalid, output wready,
		output bvalid, input bready
	);

endinterface

`default_nettype wire

// File: src/npc_pkg.sv
`default_nettype none

package npc_pkg;

	// ******************************
	// widths and sizes
	// ******************************

	// data word width
	localparam int XLEN = 64;
	// bus address and pc width
	localparam int ADDR_W = 32;
	// rv instruction width
	localparam int INST_W = 32;
	// sram depth in data words
	localparam int MEM_WORDS = 512;
	// byte offset bits inside a data word
	localparam int OFF_W = $clog2(XLEN / 8);
	// word index bits of the sram
	localparam int IDX_W = $clog2(MEM_WORDS);
	// first fetch address
	localparam logic [ADDR_W-1:0] RESET_PC = 32'h0000_0000;

	// ******************************
	// shared types
	// ******************************

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [XLEN-1:0] data_t;
	typedef logic [INST_W-1:0] inst_t;
	typedef logic [XLEN/8-1:0] strb_t;
	typedef logic [IDX_W-1:0] word_idx_t;

	// fetch fsm
	typedef enum logic [1:0] {IDLE_ADDR, WAIT_DATA, HOLD_INST} fetch_state_t;
	// load/store fsm
	typedef enum logic [2:0] {IDLE, RD_ADDR, RD_DATA, WR_REQ, WR_RESP} lsu_state_t;
	// who holds the shared read channel
	typedef enum logic [1:0] {OWN_NONE, OWN_FETCH, OWN_LSU} arb_owner_t;

endpackage

`default_nettype wire

// File: src/npc_top.sv
`timescale 1ns/1ps
`default_nettype none

module npc_top import npc_pkg::*; (
	input logic clk,
	input logic rst,
	// pipeline side of fetch
	input logic inst_ready,
	input logic redirect,
	input addr_t redirect_pc,
	// pipeline side of load/store
	input logic ls_req,
	input logic ls_write,
	input addr_t ls_addr,
	input data_t ls_wdata,
	input strb_t ls_strb,
	output addr_t pc,
	output inst_t inst,
	output logic inst_valid,
	output logic ls_busy,
	output logic ls_done,
	output data_t ls_rdata
);

	// one bus per master, one towards the sram
	mem_bus_if fetch_bus ();
	mem_bus_if lsu_bus ();
	mem_bus_if mem_bus ();

	// fetch write channels idle
	assign fetch_bus.awaddr = '0;
	assign fetch_bus.awvalid = 1'b0;
	assign fetch_bus.wdata = '0;
	assign fetch_bus.wstrb = '0;
	assign fetch_bus.wvalid = 1'b0;
	assign fetch_bus.bready = 1'b0;

	fetch_unit u_fetch (
		.clk(clk), .rst(rst), .inst_ready(inst_ready), .redirect(redirect),
		.redirect_pc(redirect_pc), .pc(pc), .inst(inst), .inst_valid(inst_valid),
		.bus(fetch_bus)
	);

	lsu u_lsu (
		.clk(clk), .rst(rst), .ls_req(ls_req), .ls_write(ls_write), .ls_addr(ls_addr),
		.ls_wdata(ls_wdata), .ls_strb(ls_strb), .ls_busy(ls_busy), .ls_done(ls_done),
		.ls_rdata(ls_rdata), .bus(lsu_bus)
	);

	// lsu wins ties on the read channel
	bus_arbiter u_arbiter (
		.clk(clk), .rst(rst), .fetch_bus(fetch_bus), .lsu_bus(lsu_bus), .mem_bus(mem_bus)
	);

	sram_mem u_sram (.clk(clk), .rst(rst), .bus(mem_bus));

endmodule

`default_nettype wire

// File: src/sram_mem.sv
`timescale 1ns/1ps
`default_nettype none

module sram_mem import npc_pkg::*; (
	input logic clk,
	input logic rst,
	mem_bus_if.slave bus
);

	// word storage
	data_t mem [MEM_WORDS];
	word_idx_t rd_idx;
	word_idx_t wr_idx;
	logic rvalid_q;
	logic bvalid_q;
	data_t rdata_q;
	logic ar_fire;
	logic wr_ok;

	// word index, upper address bits wrap around the depth
	assign rd_idx = bus.araddr[OFF_W +: IDX_W];
	assign wr_idx = bus.awaddr[OFF_W +: IDX_W];

	// ******************************
	// read port
	// ******************************

	// one response pending at most
	assign bus.arready = !rvalid_q;
	assign bus.rvalid = rvalid_q;
	assign bus.rdata = rdata_q;
	assign ar_fire = bus.arvalid && bus.arready;

	always_ff @(posedge clk) begin
		if (rst)
			rvalid_q <= 1'b0;
		else if (ar_fire)
			rvalid_q <= 1'b1;
		else if (bus.rready)
			rvalid_q <= 1'b0;
	end

	// registered read data
	always_ff @(posedge clk) begin
		if (ar_fire)
			rdata_q <= mem[rd_idx];
	end

	// ******************************
	// write port
	// ******************************

	// aw and w accepted together on one edge
	assign wr_ok = bus.awvalid && bus.wvalid && !bvalid_q;
	assign bus.awready = wr_ok;
	assign bus.wready = wr_ok;
	assign bus.bvalid = bvalid_q;

	always_ff @(posedge clk) begin
		if (rst)
			bvalid_q <= 1'b0;
		else if (wr_ok)
			bvalid_q <= 1'b1;
		else if (bus.bready)
			bvalid_q <= 1'b0;
	end

	// zeroed contents for simulation start
	initial begin
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] = '0;
	end

	// byte merge under wstrb
	always @(posedge clk) begin
		if (wr_ok) begin
			for (int b = 0; b < XLEN / 8; b++) begin
				if (bus.wstrb[b])
					mem[wr_idx][b*8 +: 8] <= bus.wdata[b*8 +: 8];
			end
		end
	end

	// ******************************
	// checks
	// ******************************

	a_no_ar_while_pending: assert property (@(posedge clk) disable iff (rst)
		!(bus.rvalid && bus.arready));

endmodule

`default_nettype wire

// File: tb.f
src/npc_pkg.sv
src/mem_bus_if.sv
src/fetch_unit.sv
src/lsu.sv
src/bus_arbiter.sv
src/sram_mem.sv
src/npc_top.sv
testbench/tb_npc.sv

// File: testbench/tb_npc.sv
`timescale 1ns/1ps
`default_nettype none

module tb_npc import npc_pkg::*; ();

	logic clk;
	logic rst;
	logic inst_ready;
	logic redirect;
	addr_t redirect_pc;
	logic ls_req;
	logic ls_write;
	addr_t ls_addr;
	data_t ls_wdata;
	strb_t ls_strb;
	addr_t pc;
	inst_t inst;
	logic inst_valid;
	logic ls_busy;
	logic ls_done;
	data_t ls_rdata;

	// reference memory, updated on every store issued
	data_t mem_model [MEM_WORDS];
	data_t exp_rdata;
	logic pend_load;
	// expected pc of the next shown instruction
	addr_t next_pc;
	int accepted = 0;
	logic rst_q = 1'b0;
	// snapshot for the back-pressure checks
	logic held_chk = 1'b0;
	addr_t held_pc;
	inst_t held_inst;

	npc_top dut_i (
		.clk(clk), .rst(rst), .inst_ready(inst_ready), .redirect(redirect),
		.redirect_pc(redirect_pc), .ls_req(ls_req), .ls_write(ls_write), .ls_addr(ls_addr),
		.ls_wdata(ls_wdata), .ls_strb(ls_strb), .pc(pc), .inst(inst),
		.inst_valid(inst_valid), .ls_busy(ls_busy), .ls_done(ls_done), .ls_rdata(ls_rdata)
	);

	// 4 ns period
	always #2 clk = ~clk;

	// ******************************
	// helpers
	// ******************************

	task automatic fail_run(input string why);
		$display("%s", why);
		$display(">>> FAIL");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic report_value(input string name, input logic [63:0] exp,
		input logic [63:0] act);
		fail_run($sformatf("** Error at %0t ns: %s expected %h actual %h", $time, name, exp, act));
	endtask

	// instruction half picked by pc bit 2
	function automatic inst_t inst_at(input addr_t a);
		data_t w;
		w = mem_model[a[OFF_W +: IDX_W]];
		return a[2] ? w[INST_W +: INST_W] : w[0 +: INST_W];
	endfunction

	// strobed bytes replaced, the rest kept
	function automatic data_t merge_bytes(input data_t old, input data_t wdata, input strb_t strb);
		data_t res;
		res = old;
		for (int b = 0; b < XLEN / 8; b++) begin
			if (strb[b])
				res[b*8 +: 8] = wdata[b*8 +: 8];
		end
		return res;
	endfunction

	// upper half of the sram only, fetch never gets there
	function automatic addr_t rand_data_addr();
		int unsigned idx;
		idx = 256 + ($urandom % 256);
		return addr_t'(idx * 8 + ($urandom % 8));
	endfunction

	task automatic step();
		@(posedge clk);
		#0.5;
	endtask

	task automatic wait_ls_done();
		int n;
		n = 0;
		while (!ls_done && n < 200) begin
			step();
			n++;
		end
		if (!ls_done)
			fail_run("timeout waiting for ls_done");
	endtask

	// one command, one request pulse, then wait for done
	task automatic issue_ls(input logic write, input addr_t a, input data_t wdata,
		input strb_t strb);
		step();
		ls_req = 1'b1;
		ls_write = write;
		ls_addr = a;
		ls_wdata = wdata;
		ls_strb = strb;
		pend_load = !write;
		if (write)
			mem_model[a[OFF_W +: IDX_W]] = merge_bytes(mem_model[a[OFF_W +: IDX_W]], wdata, strb);
		else
			exp_rdata = mem_model[a[OFF_W +: IDX_W]];
		step();
		ls_req = 1'b0;
		wait_ls_done();
	endtask

	task automatic redirect_to(input addr_t target);
		redirect = 1'b1;
		redirect_pc = target;
		step();
		redirect = 1'b0;
	endtask

	// take n instructions, optionally with random low spans on inst_ready
	task automatic run_fetch(input int n, input bit spans);
		int goal;
		int idle;
		int low_left;
		int prev;
		goal = accepted + n;
		idle = 0;
		low_left = 0;
		while (accepted < goal && idle < 200) begin
			if (spans && low_left > 0) begin
				inst_ready = 1'b0;
				low_left--;
			end else begin
				inst_ready = 1'b1;
				low_left = spans ? int'($urandom % 6) : 0;
			end
			prev = accepted;
			step();
			idle = (accepted == prev) ? idle + 1 : 0;
		end
		inst_ready = 1'b0;
		if (accepted < goal)
			fail_run("timeout waiting for inst_valid");
	endtask

	// ******************************
	// fetch order model
	// ******************************

	always @(posedge clk) begin
		rst_q <= rst;
		held_chk <= !rst && inst_valid && !inst_ready && !redirect;
		held_pc <= pc;
		held_inst <= inst;
		// redirect beats acceptance
		if (rst) begin
			next_pc <= RESET_PC;
		end else if (redirect) begin
			next_pc <= redirect_pc;
		end else if (inst_valid && inst_ready) begin
			next_pc <= next_pc + 32'd4;
			accepted <= accepted + 1;
		end
	end

	// ******************************
	// checks
	// ******************************

	// reset edges and the cycle after
	a_reset_pc: assert property (@(posedge clk) rst_q |-> pc == RESET_PC)
		else report_value("pc", 64'(RESET_PC), 64'($sampled(pc)));
	a_reset_valid: assert property (@(posedge clk) rst_q |-> !inst_valid)
		else report_value("inst_valid", 64'(1'b0), 64'($sampled(inst_valid)));
	a_reset_busy: assert property (@(posedge clk) rst_q |-> !ls_busy)
		else report_value("ls_busy", 64'(1'b0), 64'($sampled(ls_busy)));
	a_reset_done: assert property (@(posedge clk) rst_q |-> !ls_done)
		else report_value("ls_done", 64'(1'b0), 64'($sampled(ls_done)));

	// no skip, no repeat, redirect target first
	a_pc_order: assert property (@(posedge clk) disable iff (rst) inst_valid |-> pc == next_pc)
		else report_value("pc", 64'($sampled(next_pc)), 64'($sampled(pc)));
	a_inst_data: assert property (@(posedge clk) disable iff (rst)
		inst_valid |-> inst == inst_at(pc))
		else report_value("inst", 64'(inst_at($sampled(pc))), 64'($sampled(inst)));

	// held under back-pressure
	a_hold_valid: assert property (@(posedge clk) disable iff (rst) held_chk |-> inst_valid)
		else report_value("inst_valid", 64'(1'b1), 64'($sampled(inst_valid)));
	a_hold_pc: assert property (@(posedge clk) disable iff (rst) held_chk |-> pc == held_pc)
		else report_value("pc", 64'($sampled(held_pc)), 64'($sampled(pc)));
	a_hold_inst: assert property (@(posedge clk) disable iff (rst)
		held_chk |-> inst == held_inst)
		else report_value("inst", 64'($sampled(held_inst)), 64'($sampled(inst)));

	a_load_data: assert property (@(posedge clk) disable iff (rst)
		ls_done && pend_load |-> ls_rdata == exp_rdata)
		else report_value("ls_rdata", $sampled(exp_rdata), $sampled(ls_rdata));

	// ******************************
	// stimulus
	// ******************************

	initial begin
		addr_t a;
		int k;
		clk = 1'b0;
		rst = 1'b1;
		inst_ready = 1'b0;
		redirect = 1'b0;
		redirect_pc = '0;
		ls_req = 1'b0;
		ls_write = 1'b0;
		ls_addr = '0;
		ls_wdata = '0;
		ls_strb = '0;
		pend_load = 1'b0;
		exp_rdata = '0;
		for (int i = 0; i < MEM_WORDS; i++)
			mem_model[i] = '0;
		void'($urandom(32'h1f9e2073));

		repeat (3) step();
		rst = 1'b0;

		// fetch parks on pc 0 while inst_ready is low
		repeat (20) begin
			a = rand_data_addr();
			issue_ls(1'b1, a, {$urandom, $urandom}, strb_t'($urandom));
			issue_ls(1'b1, a, {$urandom, $urandom}, strb_t'($urandom));
			issue_ls(1'b0, a, '0, '0);
		end

		// program in words 32..63
		for (k = 0; k < 32; k++)
			issue_ls(1'b1, addr_t'(32'h100 + k * 8), {$urandom, $urandom}, 8'hff);

		// straight stream, then random stalls
		redirect_to(32'h0000_0100);
		run_fetch(20, 1'b0);
		run_fetch(30, 1'b1);

		// redirect lands in any fetch state
		repeat (8) begin
			k = int'($urandom % 7);
			repeat (k) begin
				inst_ready = 1'($urandom);
				step();
			end
			redirect_to(addr_t'(32'h100 + ($urandom % 48) * 4));
			run_fetch(3, 1'b1);
		end

		// lsu and fetch fight for the read channel
		redirect_to(32'h0000_0100);
		fork
			run_fetch(40, 1'b1);
			repeat (12) begin
				a = rand_data_addr();
				issue_ls(1'b1, a, {$urandom, $urandom}, strb_t'($urandom));
				issue_ls(1'b0, a, '0, '0);
				issue_ls(1'b0, rand_data_addr(), '0, '0);
			end
		join

		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire
